//--- hdc_macros.svh
`ifndef HDC_MACROS_SVH
`define HDC_MACROS_SVH

// --------------------
// hypervector geometry
// --------------------

// one generator word, four words per hypervector
`define HDC_WORD_W 32
`define HDC_WORDS 4
`define HDC_DIM (`HDC_WORD_W * `HDC_WORDS)

// item memory address, 64 entries
`define HDC_ITEM_AW 6

// instruction field of the slave stream
`define HDC_INSTR_W 16

// --------------------
// register map
// --------------------
`define HDC_AXIL_AW 12
`define HDC_REG_MODE 12'h000
`define HDC_REG_COUNT 12'h004

// xorshift start value
`define HDC_XS_SEED 32'd2463534242

`endif

//--- hdc_pkg.sv
`include "hdc_macros.svh"

package hdc_pkg;

    // one hypervector and its item memory address
    typedef logic [`HDC_DIM-1:0] hv_t;
    typedef logic [`HDC_ITEM_AW-1:0] item_addr_t;

    // word position inside a hypervector
    typedef logic [$clog2(`HDC_WORDS)-1:0] word_idx_t;

    // mode register, {run, gen}
    typedef struct packed {
        logic run;
        logic gen;
    } mode_t;

    // generate phase step from the sequencer
    typedef struct packed {
        word_idx_t  word_idx;
        logic       update_item;
        item_addr_t item_a;
    } gen_step_t;

    // read request into the item memory
    typedef struct packed {
        logic       valid;
        item_addr_t addr;
    } mem_rd_req_t;

    // one output stream beat
    typedef struct packed {
        hv_t  data;
        logic last;
    } stream_beat_t;

endpackage

//--- xorshift32.sv
`timescale 1ns/1ps
`include "hdc_macros.svh"

module xorshift32 (
    input  logic                   AXIS_ACLK,
    input  logic                   gen,
    output logic [`HDC_WORD_W-1:0] rand_word
);

    logic [`HDC_WORD_W-1:0] state;
    logic [`HDC_WORD_W-1:0] s13;
    logic [`HDC_WORD_W-1:0] s17;

    // xorshift step with shifts 13, 17, 5
    always_comb begin
        s13       = state ^ (state << 13);
        s17       = s13 ^ (s13 >> 17);
        rand_word = s17 ^ (s17 << 5);
    end

    // seed reload outside the generate phase
    always_ff @(posedge AXIS_ACLK) begin
        if (!gen) begin
            state <= `HDC_XS_SEED;
        end else begin
            state <= rand_word;
        end
    end

endmodule

//--- gen_sequencer.sv
`timescale 1ns/1ps
`include "hdc_macros.svh"

module gen_sequencer (
    input  logic                AXIS_ACLK,
    input  hdc_pkg::mode_t      mode,
    input  hdc_pkg::item_addr_t item_count,
    output hdc_pkg::gen_step_t  step,
    output logic                gen_done
);
    import hdc_pkg::*;

    localparam word_idx_t LAST_WORD = word_idx_t'(`HDC_WORDS - 1);

    word_idx_t  word_idx;
    logic       update_item;
    item_addr_t item_a;

    // --------------------
    // word and item counters
    // --------------------

    // everything sits at zero outside the generate phase
    always_ff @(posedge AXIS_ACLK) begin
        if (!mode.gen) begin
            word_idx    <= '0;
            update_item <= 1'b0;
            item_a      <= '0;
        end else begin
            if (word_idx == LAST_WORD) begin
                word_idx <= '0;
            end else begin
                word_idx <= word_idx + 1'b1;
            end

            // one cycle after the last word has been captured
            update_item <= (word_idx == LAST_WORD);

            if (update_item) begin
                item_a <= item_a + 1'b1;
            end
        end
    end

    always_comb begin
        step.word_idx    = word_idx;
        step.update_item = update_item;
        step.item_a      = item_a;
    end

    // last entry is item_count itself, so count+1 vectors in total
    assign gen_done = mode.gen & update_item & (item_a == item_count);

endmodule

//--- item_memory.sv
`timescale 1ns/1ps
`include "hdc_macros.svh"

module item_memory (
    input  logic                   AXIS_ACLK,
    input  hdc_pkg::gen_step_t     step,
    input  logic [`HDC_WORD_W-1:0] rand_word,
    input  hdc_pkg::mem_rd_req_t   rd_req,
    output hdc_pkg::hv_t           rd_data
);
    import hdc_pkg::*;

    localparam int DEPTH = 1 << `HDC_ITEM_AW;

    hv_t hold;
    hv_t mem [0:DEPTH-1];

    // --------------------
    // vector assembly
    // --------------------

    // word k lands at bits 32k upward
    always_ff @(posedge AXIS_ACLK) begin
        hold[step.word_idx * `HDC_WORD_W +: `HDC_WORD_W] <= rand_word;
    end

    // hold is complete in the update_item cycle
    always_ff @(posedge AXIS_ACLK) begin
        if (step.update_item) begin
            mem[step.item_a] <= hold;
        end
    end

    // --------------------
    // read port
    // --------------------

    // data stays put between requests, the stream relies on that while stalled
    always_ff @(posedge AXIS_ACLK) begin
        if (rd_req.valid) begin
            rd_data <= mem[rd_req.addr];
        end
    end

endmodule

//--- item_lookup_stream.sv
`timescale 1ns/1ps
`include "hdc_macros.svh"

module item_lookup_stream (
    input  logic                    AXIS_ACLK,
    input  logic                    S_AXI_ARESETN,
    input  hdc_pkg::mode_t          mode,
    input  logic [`HDC_INSTR_W-1:0] s_axis_tdata,
    input  logic                    s_axis_tlast,
    input  logic                    s_axis_tvalid,
    output logic                    s_axis_tready,
    output hdc_pkg::mem_rd_req_t    rd_req,
    input  hdc_pkg::hv_t            rd_data,
    output logic [`HDC_DIM-1:0]     m_axis_tdata,
    output logic                    m_axis_tlast,
    output logic                    m_axis_tvalid,
    input  logic                    m_axis_tready
);
    import hdc_pkg::*;

    logic         accept;
    logic         s1_valid;
    logic         s1_last;
    logic         s1_adv;
    logic         s2_valid;
    stream_beat_t s2_beat;

    // stage 1 moves on when stage 2 is empty or handing its beat over
    assign s1_adv        = ~s2_valid | m_axis_tready;
    assign s_axis_tready = mode.run & ~mode.gen & (~s1_valid | s1_adv);
    assign accept        = s_axis_tvalid & s_axis_tready;

    // the read goes out in the accept cycle
    always_comb begin
        rd_req.valid = accept;
        rd_req.addr  = s_axis_tdata[`HDC_ITEM_AW-1:0];
    end

    // --------------------
    // pipeline control
    // --------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            if (accept) begin
                s1_valid <= 1'b1;
            end else if (s1_adv) begin
                s1_valid <= 1'b0;
            end
            if (s1_adv) begin
                s2_valid <= s1_valid;
            end
        end
    end

    // payload
    always_ff @(posedge AXIS_ACLK) begin
        if (accept) begin
            s1_last <= s_axis_tlast;
        end
        if (s1_adv && s1_valid) begin
            s2_beat.data <= rd_data;
            s2_beat.last <= s1_last;
        end
    end

    assign m_axis_tdata  = s2_beat.data;
    assign m_axis_tlast  = s2_beat.last;
    assign m_axis_tvalid = s2_valid;

endmodule

//--- axi_lite_regs.sv
`timescale 1ns/1ps
`include "hdc_macros.svh"

module axi_lite_regs (
    input  logic                    AXIS_ACLK,
    input  logic                    S_AXI_ARESETN,
    input  logic [`HDC_AXIL_AW-1:0] s_axi_awaddr,
    input  logic                    s_axi_awvalid,
    output logic                    s_axi_awready,
    input  logic [31:0]             s_axi_wdata,
    input  logic                    s_axi_wvalid,
    output logic                    s_axi_wready,
    input  logic                    s_axi_bready,
    output logic [1:0]              s_axi_bresp,
    output logic                    s_axi_bvalid,
    input  logic [`HDC_AXIL_AW-1:0] s_axi_araddr,
    input  logic                    s_axi_arvalid,
    output logic                    s_axi_arready,
    input  logic                    s_axi_rready,
    output logic [31:0]             s_axi_rdata,
    output logic [1:0]              s_axi_rresp,
    output logic                    s_axi_rvalid,
    input  logic                    gen_done,
    output hdc_pkg::mode_t          mode,
    output hdc_pkg::item_addr_t     item_count
);
    import hdc_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_AW,
        ST_W,
        ST_AWW,
        ST_AR1,
        ST_AR2
    } state_t;

    state_t                  state;
    logic [`HDC_AXIL_AW-1:0] aw_addr_q;
    logic [`HDC_AXIL_AW-1:0] ar_addr_q;
    logic [31:0]             w_data_q;
    logic                    wr_go;
    logic [`HDC_AXIL_AW-1:0] wr_sel;
    logic [31:0]             wr_data;
    logic [`HDC_AXIL_AW-1:0] rd_sel;

    // --------------------
    // channel handshakes
    // --------------------
    assign s_axi_awready = (state == ST_IDLE) | (state == ST_W);
    assign s_axi_wready  = (state == ST_IDLE) | (state == ST_AW);
    // writes win over a read offered in the same cycle
    assign s_axi_arready = (state == ST_IDLE) & ~s_axi_awvalid & ~s_axi_wvalid;
    assign s_axi_bvalid  = (state == ST_AWW);
    assign s_axi_rvalid  = (state == ST_AR2);
    assign s_axi_bresp   = 2'b00;
    assign s_axi_rresp   = 2'b00;

    // write fires on the edge into AWW, so BVALID sees the new value
    always_comb begin
        wr_go = 1'b0;
        case (state)
            ST_IDLE: wr_go = s_axi_awvalid & s_axi_wvalid;
            ST_AW:   wr_go = s_axi_wvalid;
            ST_W:    wr_go = s_axi_awvalid;
            default: wr_go = 1'b0;
        endcase
        wr_sel  = (state == ST_AW) ? aw_addr_q : s_axi_awaddr;
        wr_sel  = {wr_sel[`HDC_AXIL_AW-1:2], 2'b00};
        wr_data = (state == ST_W) ? w_data_q : s_axi_wdata;
    end

    assign rd_sel = {ar_addr_q[`HDC_AXIL_AW-1:2], 2'b00};

    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (s_axi_awvalid && s_axi_wvalid) begin
                        state <= ST_AWW;
                    end else if (s_axi_awvalid) begin
                        state <= ST_AW;
                    end else if (s_axi_wvalid) begin
                        state <= ST_W;
                    end else if (s_axi_arvalid) begin
                        state <= ST_AR1;
                    end
                end
                ST_AW:   if (s_axi_wvalid) state <= ST_AWW;
                ST_W:    if (s_axi_awvalid) state <= ST_AWW;
                ST_AWW:  if (s_axi_bready) state <= ST_IDLE;
                ST_AR1:  state <= ST_AR2;
                ST_AR2:  if (s_axi_rready) state <= ST_IDLE;
                default: state <= ST_IDLE;
            endcase
        end
    end

    // address and data capture
    always_ff @(posedge AXIS_ACLK) begin
        if (s_axi_awready && s_axi_awvalid) aw_addr_q <= s_axi_awaddr;
        if (s_axi_wready && s_axi_wvalid) w_data_q <= s_axi_wdata;
        if (s_axi_arready && s_axi_arvalid) ar_addr_q <= s_axi_araddr;
    end

    // --------------------
    // mode and count
    // --------------------
    always_ff @(posedge AXIS_ACLK) begin
        if (!S_AXI_ARESETN) begin
            mode       <= '0;
            item_count <= '0;
        end else begin
            // software write beats the end of generation
            if (wr_go && wr_sel == `HDC_REG_MODE) begin
                mode <= mode_t'(wr_data[1:0]);
            end else if (gen_done) begin
                mode.gen <= 1'b0;
            end
            if (wr_go && wr_sel == `HDC_REG_COUNT) begin
                item_count <= wr_data[`HDC_ITEM_AW-1:0];
            end
        end
    end

    // read mux, loaded in AR1
    always_ff @(posedge AXIS_ACLK) begin
        if (state == ST_AR1) begin
            case (rd_sel)
                `HDC_REG_MODE:  s_axi_rdata <= {{30{1'b0}}, mode};
                `HDC_REG_COUNT: s_axi_rdata <= {{(32-`HDC_ITEM_AW){1'b0}}, item_count};
                default:        s_axi_rdata <= '0;
            endcase
        end
    end

endmodule

//--- hdc_top.sv
`timescale 1ns/1ps
`include "hdc_macros.svh"

module hdc_top (
    input  logic                    AXIS_ACLK,
    input  logic                    S_AXI_ARESETN,
    input  logic [`HDC_AXIL_AW-1:0] S_AXI_AWADDR,
    input  logic                    S_AXI_AWVALID,
    output logic                    S_AXI_AWREADY,
    input  logic [31:0]             S_AXI_WDATA,
    input  logic                    S_AXI_WVALID,
    output logic                    S_AXI_WREADY,
    input  logic                    S_AXI_BREADY,
    output logic [1:0]              S_AXI_BRESP,
    output logic                    S_AXI_BVALID,
    input  logic [`HDC_AXIL_AW-1:0] S_AXI_ARADDR,
    input  logic                    S_AXI_ARVALID,
    output logic                    S_AXI_ARREADY,
    input  logic                    S_AXI_RREADY,
    output logic [31:0]             S_AXI_RDATA,
    output logic [1:0]              S_AXI_RRESP,
    output logic                    S_AXI_RVALID,
    input  logic [1023:0]           S_AXIS_TDATA,
    input  logic                    S_AXIS_TLAST,
    input  logic                    S_AXIS_TVALID,
    output logic                    S_AXIS_TREADY,
    output logic [`HDC_DIM-1:0]     M_AXIS_TDATA,
    output logic                    M_AXIS_TLAST,
    output logic                    M_AXIS_TVALID,
    input  logic                    M_AXIS_TREADY
);
    import hdc_pkg::*;

    mode_t                  mode;
    item_addr_t             item_count;
    logic                   gen_done;
    gen_step_t              step;
    logic [`HDC_WORD_W-1:0] rand_word;
    mem_rd_req_t            rd_req;
    hv_t                    rd_data;

    // --------------------
    // control registers
    // --------------------
    axi_lite_regs axi_lite_regs_i (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .s_axi_awaddr  (S_AXI_AWADDR),
        .s_axi_awvalid (S_AXI_AWVALID),
        .s_axi_awready (S_AXI_AWREADY),
        .s_axi_wdata   (S_AXI_WDATA),
        .s_axi_wvalid  (S_AXI_WVALID),
        .s_axi_wready  (S_AXI_WREADY),
        .s_axi_bready  (S_AXI_BREADY),
        .s_axi_bresp   (S_AXI_BRESP),
        .s_axi_bvalid  (S_AXI_BVALID),
        .s_axi_araddr  (S_AXI_ARADDR),
        .s_axi_arvalid (S_AXI_ARVALID),
        .s_axi_arready (S_AXI_ARREADY),
        .s_axi_rready  (S_AXI_RREADY),
        .s_axi_rdata   (S_AXI_RDATA),
        .s_axi_rresp   (S_AXI_RRESP),
        .s_axi_rvalid  (S_AXI_RVALID),
        .gen_done      (gen_done),
        .mode          (mode),
        .item_count    (item_count)
    );

    // generate phase
    gen_sequencer gen_sequencer_i (
        .AXIS_ACLK  (AXIS_ACLK),
        .mode       (mode),
        .item_count (item_count),
        .step       (step),
        .gen_done   (gen_done)
    );

    xorshift32 xorshift32_i (
        .AXIS_ACLK (AXIS_ACLK),
        .gen       (mode.gen),
        .rand_word (rand_word)
    );

    item_memory item_memory_i (
        .AXIS_ACLK (AXIS_ACLK),
        .step      (step),
        .rand_word (rand_word),
        .rd_req    (rd_req),
        .rd_data   (rd_data)
    );

    // --------------------
    // run phase
    // --------------------

    // only the low instruction field carries the item address
    item_lookup_stream item_lookup_stream_i (
        .AXIS_ACLK     (AXIS_ACLK),
        .S_AXI_ARESETN (S_AXI_ARESETN),
        .mode          (mode),
        .s_axis_tdata  (S_AXIS_TDATA[`HDC_INSTR_W-1:0]),
        .s_axis_tlast  (S_AXIS_TLAST),
        .s_axis_tvalid (S_AXIS_TVALID),
        .s_axis_tready (S_AXIS_TREADY),
        .rd_req        (rd_req),
        .rd_data       (rd_data),
        .m_axis_tdata  (M_AXIS_TDATA),
        .m_axis_tlast  (M_AXIS_TLAST),
        .m_axis_tvalid (M_AXIS_TVALID),
        .m_axis_tready (M_AXIS_TREADY)
    );

endmodule

//--- tb_hdc_top.sv
`timescale 1ns/1ps
`include "hdc_macros.svh"

module tb_hdc_top;
    import hdc_pkg::*;

    localparam int BEATS = 24;

    logic AXIS_ACLK, S_AXI_ARESETN;
    logic [`HDC_AXIL_AW-1:0] S_AXI_AWADDR, S_AXI_ARADDR;
    logic [31:0] S_AXI_WDATA, S_AXI_RDATA;
    logic [1:0] S_AXI_BRESP, S_AXI_RRESP;
    logic S_AXI_AWVALID, S_AXI_AWREADY, S_AXI_WVALID, S_AXI_WREADY;
    logic S_AXI_BREADY, S_AXI_BVALID, S_AXI_ARVALID, S_AXI_ARREADY;
    logic S_AXI_RREADY, S_AXI_RVALID;
    logic [1023:0] S_AXIS_TDATA;
    logic S_AXIS_TLAST, S_AXIS_TVALID, S_AXIS_TREADY;
    hv_t M_AXIS_TDATA;
    logic M_AXIS_TLAST, M_AXIS_TVALID, M_AXIS_TREADY;

    int seed = 82254;
    int cycle = 0;
    int count;
    int errors = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    int test_start_errors = 0;
    hv_t model_mem [0:63];
    logic [31:0] instr_list [BEATS];
    logic last_list [BEATS];
    stream_beat_t expected_q [$];
    int accept_cycle_q [$];

    hdc_top hdc_top_i (.*);

    initial AXIS_ACLK = 1'b0;
    always #2 AXIS_ACLK = ~AXIS_ACLK;
    always @(posedge AXIS_ACLK) cycle <= cycle + 1;

    // --------------------
    // checks and report
    // --------------------
    task automatic compare_value(input string name, input logic [127:0] got,
                                 input logic [127:0] want);
        assert (got === want) else begin
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, want);
            errors++;
        end
    endtask

    task automatic check_condition(input bit ok, input string what);
        assert (ok) else begin
            $display("%s", what);
            errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (errors == test_start_errors) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    // xorshift 13, 17, 5 and the item table it produces
    function automatic logic [31:0] xs_next(input logic [31:0] s);
        logic [31:0] t;
        t = s ^ (s << 13);
        t = t ^ (t >> 17);
        return t ^ (t << 5);
    endfunction

    task automatic build_model(input int last_item);
        logic [31:0] s;
        s = `HDC_XS_SEED;
        for (int j = 0; j <= last_item; j++) begin
            for (int k = 0; k < `HDC_WORDS; k++) begin
                s = xs_next(s);
                model_mem[j][k*`HDC_WORD_W +: `HDC_WORD_W] = s;
            end
        end
    endtask

    // --------------------
    // AXI-Lite master
    // --------------------
    task automatic axil_write(input logic [11:0] addr, input logic [31:0] data, input int order);
        bit aw_done;
        bit w_done;
        bit aw_hs;
        bit w_hs;
        aw_done = 1'b0;
        w_done  = 1'b0;
        @(negedge AXIS_ACLK);
        S_AXI_AWADDR  = addr;
        S_AXI_WDATA   = data;
        // order 0 address first, 1 data first, 2 both together
        S_AXI_AWVALID = (order != 1);
        S_AXI_WVALID  = (order != 0);
        while (!(aw_done && w_done)) begin
            #1;
            aw_hs = S_AXI_AWVALID && S_AXI_AWREADY;
            w_hs  = S_AXI_WVALID && S_AXI_WREADY;
            @(negedge AXIS_ACLK);
            aw_done = aw_done | aw_hs;
            w_done  = w_done | w_hs;
            // the channel already taken waits with its ready low
            if (aw_done != w_done) begin
                compare_value("S_AXI_AWREADY", S_AXI_AWREADY, w_done);
                compare_value("S_AXI_WREADY", S_AXI_WREADY, aw_done);
            end
            S_AXI_AWVALID = !aw_done && (order != 1 || w_done);
            S_AXI_WVALID  = !w_done && (order != 0 || aw_done);
        end
        #1;
        check_condition(S_AXI_BVALID, "BVALID did not rise the cycle after the write");
        compare_value("S_AXI_BRESP", S_AXI_BRESP, 0);
        @(posedge AXIS_ACLK);
    endtask

    task automatic axil_read(input logic [11:0] addr, output logic [31:0] data);
        @(negedge AXIS_ACLK);
        S_AXI_ARADDR  = addr;
        S_AXI_ARVALID = 1'b1;
        #1;
        while (!S_AXI_ARREADY) begin
            @(negedge AXIS_ACLK);
            #1;
        end
        @(negedge AXIS_ACLK);
        S_AXI_ARVALID = 1'b0;
        #1;
        check_condition(!S_AXI_RVALID, "RVALID came one cycle after the read address");
        @(negedge AXIS_ACLK);
        #1;
        check_condition(S_AXI_RVALID, "RVALID missing two cycles after the read address");
        compare_value("S_AXI_RRESP", S_AXI_RRESP, 0);
        data = S_AXI_RDATA;
        @(posedge AXIS_ACLK);
    endtask

    // --------------------
    // instruction and result streams
    // --------------------
    task automatic prepare_beats();
        for (int i = 0; i < BEATS; i++) begin
            instr_list[i] = $random(seed);
            instr_list[i][5:0] = $unsigned($random(seed)) % (count + 1);
            last_list[i] = ($random(seed) % 4 == 0) || (i == BEATS - 1);
        end
    endtask

    task automatic send_beats();
        for (int i = 0; i < BEATS; i++) begin
            @(negedge AXIS_ACLK);
            S_AXIS_TDATA = '0;
            S_AXIS_TDATA[31:0] = instr_list[i];
            S_AXIS_TLAST  = last_list[i];
            S_AXIS_TVALID = 1'b1;
            #1;
            while (!S_AXIS_TREADY) begin
                @(negedge AXIS_ACLK);
                #1;
            end
            expected_q.push_back({model_mem[instr_list[i][5:0]], last_list[i]});
            accept_cycle_q.push_back(cycle);
        end
        @(negedge AXIS_ACLK);
        S_AXIS_TVALID = 1'b0;
    endtask

    task automatic receive_beats(input bit backpressure);
        int           got;
        bit           stalled;
        stream_beat_t held;
        stream_beat_t want;
        int           latency;
        got     = 0;
        stalled = 1'b0;
        while (got < BEATS) begin
            @(negedge AXIS_ACLK);
            M_AXIS_TREADY = !backpressure || ($random(seed) % 3 == 0);
            #1;
            // a stalled beat must not move
            if (stalled) begin
                check_condition(M_AXIS_TVALID, "M_AXIS_TVALID dropped while stalled");
                compare_value("M_AXIS_TDATA", M_AXIS_TDATA, held.data);
                compare_value("M_AXIS_TLAST", M_AXIS_TLAST, held.last);
            end
            stalled = M_AXIS_TVALID && !M_AXIS_TREADY;
            held    = {M_AXIS_TDATA, M_AXIS_TLAST};
            if (M_AXIS_TVALID && M_AXIS_TREADY) begin
                check_condition(expected_q.size() != 0, "output beat with none outstanding");
                want    = expected_q.pop_front();
                latency = cycle - accept_cycle_q.pop_front();
                compare_value("M_AXIS_TDATA", M_AXIS_TDATA, want.data);
                compare_value("M_AXIS_TLAST", M_AXIS_TLAST, want.last);
                if (!backpressure) begin
                    compare_value("M_AXIS_TVALID latency", latency, 2);
                end
                got++;
            end
        end
    endtask

    task automatic run_stream(input bit backpressure);
        prepare_beats();
        fork
            send_beats();
            receive_beats(backpressure);
        join
        repeat (4) begin
            @(negedge AXIS_ACLK);
            #1;
            check_condition(!M_AXIS_TVALID, "extra output beat after the last one");
        end
    endtask

    // --------------------
    // test sequence
    // --------------------
    initial begin
        logic [31:0] rd;
        bit          ready_seen;
        count = 32 + ($unsigned($random(seed)) % 32);
        S_AXI_ARESETN = 1'b0;
        S_AXI_AWADDR  = '0;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WDATA   = '0;
        S_AXI_WVALID  = 1'b0;
        S_AXI_BREADY  = 1'b1;
        S_AXI_ARADDR  = '0;
        S_AXI_ARVALID = 1'b0;
        S_AXI_RREADY  = 1'b1;
        S_AXIS_TDATA  = '0;
        S_AXIS_TLAST  = 1'b0;
        S_AXIS_TVALID = 1'b0;
        M_AXIS_TREADY = 1'b1;
        repeat (5) @(negedge AXIS_ACLK);
        S_AXI_ARESETN = 1'b1;
        #1;
        check_condition(!S_AXI_BVALID && !S_AXI_RVALID, "AXI-Lite response valid after reset");
        check_condition(!M_AXIS_TVALID && !S_AXIS_TREADY, "stream handshake high after reset");
        axil_read(`HDC_REG_MODE, rd);
        compare_value("S_AXI_RDATA mode", rd, 0);
        axil_read(`HDC_REG_COUNT, rd);
        compare_value("S_AXI_RDATA count", rd, 0);
        end_test("reset");

        axil_write(`HDC_REG_COUNT, 32'hABCD_EF5A, 0);
        axil_read(`HDC_REG_COUNT, rd);
        compare_value("S_AXI_RDATA count", rd, 32'h1A);
        axil_write(`HDC_REG_MODE, 32'hFFFF_FFFE, 1);
        axil_read(`HDC_REG_MODE, rd);
        compare_value("S_AXI_RDATA mode", rd, 32'h2);
        axil_write(`HDC_REG_MODE, 32'h0, 2);
        axil_write(12'hC04, 32'h3F, 2);
        axil_read(`HDC_REG_COUNT, rd);
        compare_value("S_AXI_RDATA count", rd, 32'h1A);
        axil_read(12'h008, rd);
        compare_value("S_AXI_RDATA unmapped", rd, 0);
        axil_read(12'hC04, rd);
        compare_value("S_AXI_RDATA high address", rd, 0);
        end_test("registers");

        axil_write(`HDC_REG_COUNT, count, 2);
        build_model(count);
        // run set as well, so only gen holds the stream off
        axil_write(`HDC_REG_MODE, 32'h3, 0);
        do begin
            @(negedge AXIS_ACLK);
            #1;
            ready_seen = S_AXIS_TREADY;
            axil_read(`HDC_REG_MODE, rd);
            if (rd[0]) begin
                check_condition(!ready_seen, "S_AXIS_TREADY high during generation");
            end
        end while (rd[0]);
        @(negedge AXIS_ACLK);
        #1;
        check_condition(S_AXIS_TREADY, "S_AXIS_TREADY still low after generation");
        end_test("generation");

        axil_write(`HDC_REG_MODE, 32'h2, 2);
        run_stream(1'b0);
        end_test("lookup");
        run_stream(1'b1);
        check_condition(expected_q.size() == 0, "beats left over after back-pressure");
        end_test("back-pressure");

        $display("tests: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    // limit from register traffic, generation length and both streams
    initial begin
        #1;
        #(2 * (300 + 8 * (count + 1) + 20 * BEATS) * 4);
        $display("timeout: the run did not reach its end in time");
        $display("Something failed");
        $finish;
    end

endmodule

//--- files.f
+incdir+.
hdc_pkg.sv
xorshift32.sv
gen_sequencer.sv
item_memory.sv
item_lookup_stream.sv
axi_lite_regs.sv
hdc_top.sv
tb_hdc_top.sv
